// File: design/end_audit.sv
//----------------------------------------
// end-of-test audit
// transaction counts and leftover queue entries
//----------------------------------------
module end_audit import mem_mon_pkg::*; #(
  parameter int unsigned DEPTH = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        end_sim_i,
  input  logic                        req_seen_i,
  input  logic [1:0]                  words_pred_i,
  input  logic                        resp_seen_i,
  input  logic                        words_seen_i,
  input  logic [3:0][$clog2(DEPTH):0] occupancy_i,
  input  logic                        overflow_i,
  output audit_t                      audit_o
);

  logic        end_sim_q;
  logic        end_dly_q;
  logic [31:0] req_cnt_q;
  logic [31:0] resp_cnt_q;
  logic [31:0] pred_cnt_q;
  logic [31:0] obs_cnt_q;
  logic        mismatch;
  logic        pending;

  assign mismatch = (req_cnt_q != resp_cnt_q) || (pred_cnt_q != obs_cnt_q);
  assign pending  = |occupancy_i;

  // ------------------------------------
  // counters
  // ------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_cnt_q  <= '0;
      resp_cnt_q <= '0;
      pred_cnt_q <= '0;
      obs_cnt_q  <= '0;
    end else begin
      req_cnt_q  <= req_cnt_q + {31'd0, req_seen_i};
      resp_cnt_q <= resp_cnt_q + {31'd0, resp_seen_i};
      pred_cnt_q <= pred_cnt_q + {30'd0, words_pred_i};
      obs_cnt_q  <= obs_cnt_q + {31'd0, words_seen_i};
    end
  end

  // ------------------------------------
  // rising edge, one settle cycle, then report
  // ------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_sim_q <= 1'b0;
      end_dly_q <= 1'b0;
      audit_o   <= '0;
    end else begin
      end_sim_q              <= end_sim_i;
      end_dly_q              <= end_sim_i && !end_sim_q;
      audit_o.done           <= end_dly_q;
      audit_o.count_mismatch <= end_dly_q && mismatch;
      audit_o.pending        <= end_dly_q && pending;
      audit_o.overflow       <= end_dly_q && overflow_i;
    end
  end

endmodule

// File: design/lsu_word_split.sv
//----------------------------------------
// LSU word splitter
// predicts the memory word commands of one request
//----------------------------------------
module lsu_word_split import mem_mon_pkg::*; (
  input  lsu_req_t   req_i,
  output word_pair_t pair_o
);

  logic [1:0]  offset;
  logic [7:0]  be8;
  logic [63:0] data64;

  assign offset = req_i.addr[1:0];

  // upper half is the store data rotated left by offset bytes
  assign data64 = {req_i.wdata, req_i.wdata} << {offset, 3'b000};

  // byte enables over the two-word window
  always_comb begin
    unique case (req_i.size)
      SIZE_WORD: be8 = 8'h0F << offset;
      SIZE_HALF: be8 = 8'h03 << offset;
      default:   be8 = 8'h01 << offset;
    endcase
  end

  always_comb begin
    pair_o.two = req_spans(req_i);

    pair_o.w0.is_cap = req_i.is_cap;
    pair_o.w0.we     = req_i.we;
    pair_o.w0.addr32 = req_i.addr[31:2];
    pair_o.w0.rdata  = '0;
    pair_o.w0.err    = 1'b0;

    pair_o.w1.is_cap = req_i.is_cap;
    pair_o.w1.we     = req_i.we;
    pair_o.w1.addr32 = req_i.addr[31:2] + 30'd1;
    pair_o.w1.rdata  = '0;
    pair_o.w1.err    = 1'b0;

    if (req_i.is_cap) begin
      // capability is two full words with the low word first
      pair_o.w0.be    = 4'hF;
      pair_o.w1.be    = 4'hF;
      pair_o.w0.wdata = req_i.wdata;
      pair_o.w1.wdata = req_i.wdata_hi;
    end else begin
      pair_o.w0.be    = be8[3:0];
      pair_o.w1.be    = be8[7:4];
      pair_o.w0.wdata = data64[63:32];
      pair_o.w1.wdata = data64[63:32];
    end
  end

endmodule

// File: design/mem_mon_pkg.sv
//----------------------------------------
// memory monitor package
// shared types, cause bits and the word spanning rule
//----------------------------------------
package mem_mon_pkg;

  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } access_size_e;

  // request accepted by the LSU
  typedef struct packed {
    logic         is_cap;
    logic         we;
    access_size_e size;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  wdata_hi;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] rdata_hi;
    logic        err;
  } lsu_resp_t;

  // one data memory word, predicted or observed
  typedef struct packed {
    logic        is_cap;
    logic        we;
    logic [3:0]  be;
    logic [29:0] addr32;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
  } mem_word_t;

  typedef struct packed {
    logic      two;
    mem_word_t w0;
    mem_word_t w1;
  } word_pair_t;

  typedef struct packed {
    logic       valid;
    logic       fail;
    logic [7:0] cause;
  } chk_result_t;

  typedef struct packed {
    logic done;
    logic count_mismatch;
    logic pending;
    logic overflow;
  } audit_t;

  // cause bit positions
  localparam int unsigned MEM_CAUSE_ATTR  = 0;
  localparam int unsigned MEM_CAUSE_ADDR  = 1;
  localparam int unsigned SRC_CAUSE_ERR   = 0;
  localparam int unsigned SRC_CAUSE_W0    = 1;
  localparam int unsigned SRC_CAUSE_W1    = 2;
  localparam int unsigned SRC_CAUSE_WDATA = 3;
  localparam int unsigned SRC_CAUSE_RDATA = 4;

  // true when the request needs two memory words
  function automatic logic req_spans(lsu_req_t req);
    logic [1:0] offset;
    offset = req.addr[1:0];
    return req.is_cap ||
           ((req.size == SIZE_WORD) && (offset != 2'd0)) ||
           ((req.size == SIZE_HALF) && (offset == 2'd3));
  endfunction

endpackage

// File: design/mem_mon_top.sv
//----------------------------------------
// memory monitor top level
// LSU to memory to LSU end-to-end checking
//----------------------------------------
module mem_mon_top import mem_mon_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        lsu_req_valid_i,
  input  lsu_req_t    lsu_req_i,
  input  logic        mem_valid_i,
  input  mem_word_t   mem_word_i,
  input  logic        lsu_resp_valid_i,
  input  lsu_resp_t   lsu_resp_i,
  input  logic        end_sim_i,
  output chk_result_t mem_chk_o,
  output chk_result_t src_chk_o,
  output audit_t      audit_o
);

  localparam int unsigned CW = $clog2(FIFO_DEPTH) + 1;

  word_pair_t pair_new;
  word_pair_t pred_head;
  mem_word_t  obs_head;
  mem_word_t  fwd_word;
  mem_word_t  fwd_head;
  lsu_req_t   req_head;
  lsu_resp_t  resp_head;

  logic pred_empty, obs_empty, fwd_empty, req_empty, resp_empty;
  logic pred_pop, obs_pop, fwd_pop, req_pop, resp_pop;
  logic fwd_push;
  logic pred_ovf, obs_ovf, fwd_ovf, req_ovf, resp_ovf;

  logic [CW-1:0]       pred_cnt, obs_cnt, fwd_cnt, req_cnt, resp_cnt;
  logic [3:0][CW-1:0]  occupancy;
  logic [1:0]          words_pred;

  lsu_word_split u_split (
    .req_i  (lsu_req_i),
    .pair_o (pair_new)
  );

  // ------------------------------------
  // queues
  // ------------------------------------
  mon_fifo #(.WIDTH($bits(word_pair_t)), .DEPTH(FIFO_DEPTH)) u_pred_fifo (
    .clk_i, .rst_ni,
    .push_i (lsu_req_valid_i), .data_i (pair_new), .pop_i (pred_pop),
    .data_o (pred_head), .empty_o (pred_empty), .count_o (pred_cnt), .overflow_o (pred_ovf)
  );

  mon_fifo #(.WIDTH($bits(mem_word_t)), .DEPTH(FIFO_DEPTH)) u_obs_fifo (
    .clk_i, .rst_ni,
    .push_i (mem_valid_i), .data_i (mem_word_i), .pop_i (obs_pop),
    .data_o (obs_head), .empty_o (obs_empty), .count_o (obs_cnt), .overflow_o (obs_ovf)
  );

  mon_fifo #(.WIDTH($bits(mem_word_t)), .DEPTH(FIFO_DEPTH)) u_fwd_fifo (
    .clk_i, .rst_ni,
    .push_i (fwd_push), .data_i (fwd_word), .pop_i (fwd_pop),
    .data_o (fwd_head), .empty_o (fwd_empty), .count_o (fwd_cnt), .overflow_o (fwd_ovf)
  );

  mon_fifo #(.WIDTH($bits(lsu_req_t)), .DEPTH(FIFO_DEPTH)) u_req_fifo (
    .clk_i, .rst_ni,
    .push_i (lsu_req_valid_i), .data_i (lsu_req_i), .pop_i (req_pop),
    .data_o (req_head), .empty_o (req_empty), .count_o (req_cnt), .overflow_o (req_ovf)
  );

  mon_fifo #(.WIDTH($bits(lsu_resp_t)), .DEPTH(FIFO_DEPTH)) u_resp_fifo (
    .clk_i, .rst_ni,
    .push_i (lsu_resp_valid_i), .data_i (lsu_resp_i), .pop_i (resp_pop),
    .data_o (resp_head), .empty_o (resp_empty), .count_o (resp_cnt), .overflow_o (resp_ovf)
  );

  // ------------------------------------
  // checkers
  // ------------------------------------
  mem_word_checker u_mem_chk (
    .clk_i, .rst_ni,
    .pred_i (pred_head), .pred_empty_i (pred_empty),
    .obs_i (obs_head), .obs_empty_i (obs_empty),
    .pred_pop_o (pred_pop), .obs_pop_o (obs_pop),
    .fwd_push_o (fwd_push), .fwd_word_o (fwd_word),
    .mem_chk_o
  );

  src_resp_checker u_src_chk (
    .clk_i, .rst_ni,
    .req_i (req_head), .req_empty_i (req_empty),
    .resp_i (resp_head), .resp_empty_i (resp_empty),
    .word_i (fwd_head), .word_empty_i (fwd_empty),
    .req_pop_o (req_pop), .resp_pop_o (resp_pop), .word_pop_o (fwd_pop),
    .src_chk_o
  );

  // request and response queues share a slot, only a nonzero value matters
  assign occupancy  = {pred_cnt, obs_cnt, fwd_cnt, req_cnt | resp_cnt};
  assign words_pred = lsu_req_valid_i ? {pair_new.two, !pair_new.two} : 2'b00;

  end_audit #(.DEPTH(FIFO_DEPTH)) u_audit (
    .clk_i, .rst_ni,
    .end_sim_i,
    .req_seen_i   (lsu_req_valid_i),
    .words_pred_i (words_pred),
    .resp_seen_i  (lsu_resp_valid_i),
    .words_seen_i (mem_valid_i),
    .occupancy_i  (occupancy),
    .overflow_i   (pred_ovf | obs_ovf | fwd_ovf | req_ovf | resp_ovf),
    .audit_o
  );

endmodule

// File: design/mem_word_checker.sv
//----------------------------------------
// memory-side checker
// compares predicted and observed words one per cycle
//----------------------------------------
module mem_word_checker import mem_mon_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  word_pair_t  pred_i,
  input  logic        pred_empty_i,
  input  mem_word_t   obs_i,
  input  logic        obs_empty_i,
  output logic        pred_pop_o,
  output logic        obs_pop_o,
  output logic        fwd_push_o,
  output mem_word_t   fwd_word_o,
  output chk_result_t mem_chk_o
);

  typedef enum logic {
    WORD0,
    WORD1
  } word_state_e;

  word_state_e state_q;
  word_state_e state_d;
  mem_word_t   exp_word;
  logic        go;
  logic        last_word;
  logic [7:0]  cause;

  assign go        = !pred_empty_i && !obs_empty_i;
  assign exp_word  = (state_q == WORD1) ? pred_i.w1 : pred_i.w0;
  assign last_word = (state_q == WORD1) || !pred_i.two;

  // the pair entry leaves only after its last word
  assign pred_pop_o = go && last_word;
  assign obs_pop_o  = go;
  assign fwd_push_o = go;
  assign fwd_word_o = obs_i;

  // data is left to the source-side check
  always_comb begin
    cause = '0;
    cause[MEM_CAUSE_ATTR] = (exp_word.is_cap != obs_i.is_cap) ||
                            (exp_word.we != obs_i.we) ||
                            (exp_word.be != obs_i.be);
    cause[MEM_CAUSE_ADDR] = (exp_word.addr32 != obs_i.addr32);
  end

  always_comb begin
    state_d = state_q;
    if (go) begin
      state_d = last_word ? WORD0 : WORD1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= WORD0;
      mem_chk_o <= '0;
    end else begin
      state_q         <= state_d;
      mem_chk_o.valid <= go;
      mem_chk_o.fail  <= go && (cause != '0);
      mem_chk_o.cause <= go ? cause : '0;
    end
  end

endmodule

// File: design/mon_fifo.sv
//----------------------------------------
// monitor FIFO
// in-order storage with occupancy and sticky overflow
//----------------------------------------
module mon_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  logic [WIDTH-1:0]       data_i,
  input  logic                   pop_i,
  output logic [WIDTH-1:0]       data_o,
  output logic                   empty_o,
  output logic [$clog2(DEPTH):0] count_o,
  output logic                   overflow_o
);

  localparam int unsigned PW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PW-1:0]    wr_ptr_q;
  logic [PW-1:0]    rd_ptr_q;
  logic [PW:0]      count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count_q == (PW + 1)'(DEPTH));
  assign do_pop  = pop_i && !empty_o;
  // a pop in the same cycle frees the slot for the push
  assign do_push = push_i && (!full || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      // pointers wrap on their own, DEPTH is a power of two
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      if (push_i && !do_push) overflow_o <= 1'b1;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

// File: design/src_resp_checker.sv
//----------------------------------------
// source-side checker
// matches each LSU response to its request and memory words
//----------------------------------------
module src_resp_checker import mem_mon_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  lsu_req_t    req_i,
  input  logic        req_empty_i,
  input  lsu_resp_t   resp_i,
  input  logic        resp_empty_i,
  input  mem_word_t   word_i,
  input  logic        word_empty_i,
  output logic        req_pop_o,
  output logic        resp_pop_o,
  output logic        word_pop_o,
  output chk_result_t src_chk_o
);

  typedef enum logic {
    COLLECT,
    HAVE_FIRST
  } collect_state_e;

  collect_state_e state_q;
  mem_word_t      first_q;
  mem_word_t      w0;
  mem_word_t      w1;
  logic           ready;
  logic           two;
  logic           finish;
  logic           data_chk;
  logic           mem_err;
  logic [7:0]     cause;

  assign ready  = !req_empty_i && !resp_empty_i && !word_empty_i;
  assign two    = req_spans(req_i);
  assign finish = ready && (!two || (state_q == HAVE_FIRST));

  assign word_pop_o = ready;
  assign req_pop_o  = finish;
  assign resp_pop_o = finish;

  // held word is the first of a pair, the head word completes it
  assign w0 = (state_q == HAVE_FIRST) ? first_q : word_i;
  assign w1 = word_i;

  assign mem_err  = w0.err || (two && w1.err);
  // partial accesses carry shifted data, only full words are compared
  assign data_chk = req_i.is_cap || ((req_i.size == SIZE_WORD) && (req_i.addr[1:0] == 2'd0));

  always_comb begin
    cause = '0;
    cause[SRC_CAUSE_ERR] = (resp_i.err != mem_err);
    if (!resp_i.err) begin
      cause[SRC_CAUSE_W0] = (w0.is_cap != req_i.is_cap) || (w0.we != req_i.we) ||
                            (w0.addr32 != req_i.addr[31:2]);
      cause[SRC_CAUSE_W1] = two &&
                            ((w1.is_cap != req_i.is_cap) || (w1.we != req_i.we) ||
                             (w1.addr32 != req_i.addr[31:2] + 30'd1));
      cause[SRC_CAUSE_WDATA] = req_i.we && data_chk &&
                               ((w0.wdata != req_i.wdata) ||
                                (req_i.is_cap && (w1.wdata != req_i.wdata_hi)));
      cause[SRC_CAUSE_RDATA] = !req_i.we && data_chk &&
                               ((w0.rdata != resp_i.rdata) ||
                                (req_i.is_cap && (w1.rdata != resp_i.rdata_hi)));
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready && (state_q == COLLECT) && two) begin
      first_q <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= COLLECT;
      src_chk_o <= '0;
    end else begin
      if (finish) begin
        state_q <= COLLECT;
      end else if (ready) begin
        state_q <= HAVE_FIRST;
      end
      src_chk_o.valid <= finish;
      src_chk_o.fail  <= finish && (cause != '0);
      src_chk_o.cause <= finish ? cause : '0;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
verilator --binary --assert --top-module tb_mem_mon -f tb.f -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Testbench passed" &&
  echo "simulation ok" ||
  { echo "simulation not ok"; exit 1; }

// File: tb.f
design/mem_mon_pkg.sv
design/mon_fifo.sv
design/lsu_word_split.sv
design/mem_word_checker.sv
design/src_resp_checker.sv
design/end_audit.sv
design/mem_mon_top.sv
testbench/tb_mem_mon_chk.sv
testbench/tb_mem_mon.sv

// File: testbench/tb_mem_mon.sv
//----------------------------------------
// memory monitor testbench
// random LSU traffic, memory model and result checks
//----------------------------------------
module tb_mem_mon import mem_mon_pkg::*; ();

  localparam int unsigned TXN_PER_TEST   = 40;
  localparam int unsigned TIMEOUT_CYCLES = 6 * TXN_PER_TEST * 15 + 400;

  // fault kinds for one transaction
  localparam int FAULT_NONE     = 0;
  localparam int FAULT_BE       = 1;
  localparam int FAULT_ADDR     = 2;
  localparam int FAULT_ERR      = 3;
  localparam int FAULT_RDATA_HI = 4;
  localparam int FAULT_NO_RESP  = 5;

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_req_valid_i;
  lsu_req_t    lsu_req_i;
  logic        mem_valid_i;
  mem_word_t   mem_word_i;
  logic        lsu_resp_valid_i;
  lsu_resp_t   lsu_resp_i;
  logic        end_sim_i;
  chk_result_t mem_chk_o;
  chk_result_t src_chk_o;
  audit_t      audit_o;

  logic [31:0] mem_model [256];
  logic [31:0] rng_state;
  logic [7:0]  exp_mem_q [$];
  logic [7:0]  exp_src_q [$];
  int unsigned check_cnt;
  int unsigned err_cnt;
  int unsigned base_checks;
  int unsigned base_errs;
  int unsigned cycle_cnt;
  lsu_req_t    req;

  mem_mon_top #(.FIFO_DEPTH(8)) mem_mon_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("timeout after %0d cycles, results still outstanding", cycle_cnt);
        $display("Testbench failed");
        $finish;
      end
    end
  end

  // ----------------------------------------
  // random numbers and reference models
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] rotl_bytes(logic [31:0] d, logic [1:0] n);
    logic [31:0] r;
    r = d;
    repeat (n) r = {r[23:0], r[31:24]};
    return r;
  endfunction

  // expected memory words of one request
  function automatic word_pair_t split_ref(lsu_req_t r);
    word_pair_t p;
    logic [1:0] off;
    off = r.addr[1:0];
    p = '0;
    p.w0.is_cap = r.is_cap;
    p.w0.we     = r.we;
    p.w0.addr32 = r.addr[31:2];
    p.w0.wdata  = r.is_cap ? r.wdata : rotl_bytes(r.wdata, off);
    p.w1        = p.w0;
    p.w1.addr32 = r.addr[31:2] + 30'd1;
    if (r.is_cap) begin
      p.two       = 1'b1;
      p.w0.be     = 4'hF;
      p.w1.be     = 4'hF;
      p.w1.wdata  = r.wdata_hi;
    end else begin
      case (r.size)
        SIZE_WORD: begin
          p.two   = (off != 2'd0);
          p.w0.be = 4'hF << off;
          p.w1.be = ~p.w0.be;
        end
        SIZE_HALF: begin
          p.two   = (off == 2'd3);
          p.w0.be = p.two ? 4'h8 : (4'h3 << off);
          p.w1.be = 4'h1;
        end
        default: begin
          p.w0.be = 4'h1 << off;
        end
      endcase
    end
    return p;
  endfunction

  // memory-side cause of a word that carries the given fault
  function automatic logic [7:0] mem_fault_cause(input int fault);
    logic [7:0] c;
    c = '0;
    if (fault == FAULT_BE) c[MEM_CAUSE_ATTR] = 1'b1;
    if (fault == FAULT_ADDR) c[MEM_CAUSE_ADDR] = 1'b1;
    return c;
  endfunction

  function automatic logic [7:0] src_ref(lsu_req_t r, logic two, mem_word_t w0, mem_word_t w1,
                                         lsu_resp_t resp);
    logic [7:0] c;
    logic       full_word;
    c = '0;
    full_word = r.is_cap || ((r.size == SIZE_WORD) && (r.addr[1:0] == 2'd0));
    c[SRC_CAUSE_ERR] = (resp.err != (w0.err || (two && w1.err)));
    if (!resp.err) begin
      c[SRC_CAUSE_W0] = (w0.is_cap != r.is_cap) || (w0.we != r.we) ||
                        (w0.addr32 != r.addr[31:2]);
      if (two) begin
        c[SRC_CAUSE_W1] = (w1.is_cap != r.is_cap) || (w1.we != r.we) ||
                          (w1.addr32 != r.addr[31:2] + 30'd1);
      end
      if (full_word && r.we) begin
        c[SRC_CAUSE_WDATA] = (w0.wdata != r.wdata) || (r.is_cap && (w1.wdata != r.wdata_hi));
      end
      if (full_word && !r.we) begin
        c[SRC_CAUSE_RDATA] = (w0.rdata != resp.rdata) ||
                             (r.is_cap && (w1.rdata != resp.rdata_hi));
      end
    end
    return c;
  endfunction

  // memory model where writes merge under the byte enables
  function automatic mem_word_t serve_word(mem_word_t w);
    mem_word_t   o;
    logic [7:0]  idx;
    logic [31:0] mask;
    o    = w;
    idx  = w.addr32[7:0];
    mask = {{8{w.be[3]}}, {8{w.be[2]}}, {8{w.be[1]}}, {8{w.be[0]}}};
    if (w.we) begin
      mem_model[idx] = (mem_model[idx] & ~mask) | (w.wdata & mask);
    end else begin
      o.rdata = mem_model[idx];
    end
    return o;
  endfunction

  // kind 0 aligned word, 1 spanning word or half, 2 byte or short half, 3 capability
  function automatic lsu_req_t rand_req(int kind);
    lsu_req_t    r;
    logic [31:0] x;
    x          = next_rand();
    r.is_cap   = 1'b0;
    r.we       = x[31];
    r.size     = SIZE_WORD;
    r.addr     = {22'd0, x[9:2], 2'b00};
    r.wdata    = next_rand();
    r.wdata_hi = next_rand();
    case (kind)
      1: begin
        if (x[12]) begin
          r.addr[1:0] = (x[11:10] == 2'd0) ? 2'd1 : x[11:10];
        end else begin
          r.size      = SIZE_HALF;
          r.addr[1:0] = 2'd3;
        end
      end
      2: begin
        r.addr[1:0] = x[11:10];
        r.size      = (x[12] && (x[11:10] != 2'd3)) ? SIZE_HALF : SIZE_BYTE;
      end
      3: begin
        r.is_cap  = 1'b1;
        r.addr[2] = 1'b0;
      end
      default: begin
      end
    endcase
    return r;
  endfunction

  // ----------------------------------------
  // checking
  // ----------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp_val,
                           input logic [31:0] got_val);
    check_cnt++;
    if (got_val !== exp_val) begin
      err_cnt++;
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp_val, got_val);
    end
  endtask

  task automatic compare_result(input string name, input logic [7:0] exp_cause,
                                input chk_result_t got);
    check_val({name, ".fail"}, 32'(exp_cause != 8'd0), 32'(got.fail));
    check_val({name, ".cause"}, 32'(exp_cause), 32'(got.cause));
  endtask

  always @(negedge clk_i) begin
    if (rst_ni && mem_chk_o.valid) begin
      if (exp_mem_q.size() == 0) begin
        err_cnt++;
        $display("result on mem_chk_o at %0t with no word expected", $time);
      end else begin
        compare_result("mem_chk_o", exp_mem_q.pop_front(), mem_chk_o);
      end
    end
    if (rst_ni && src_chk_o.valid) begin
      if (exp_src_q.size() == 0) begin
        err_cnt++;
        $display("result on src_chk_o at %0t with no request expected", $time);
      end else begin
        compare_result("src_chk_o", exp_src_q.pop_front(), src_chk_o);
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic drive_word(input logic [7:0] exp_cause, input mem_word_t obs_w);
    exp_mem_q.push_back(exp_cause);
    @(negedge clk_i);
    lsu_req_valid_i = 1'b0;
    mem_valid_i     = 1'b1;
    mem_word_i      = obs_w;
  endtask

  task automatic run_txn(input lsu_req_t r, input int fault);
    word_pair_t pred;
    mem_word_t  w0;
    mem_word_t  w1;
    lsu_resp_t  resp;
    pred = split_ref(r);
    @(negedge clk_i);
    lsu_req_valid_i = 1'b1;
    lsu_req_i       = r;
    w0 = serve_word(pred.w0);
    if (fault == FAULT_BE) w0.be = w0.be ^ 4'h1;
    if (fault == FAULT_ADDR) w0.addr32 = w0.addr32 ^ 30'h40;
    drive_word(mem_fault_cause(fault), w0);
    w1 = pred.w1;
    if (pred.two) begin
      w1 = serve_word(pred.w1);
      drive_word(8'd0, w1);
    end
    resp.rdata    = w0.rdata;
    resp.rdata_hi = r.is_cap ? w1.rdata : 32'd0;
    resp.err      = (fault == FAULT_ERR);
    if (fault == FAULT_RDATA_HI) resp.rdata_hi = resp.rdata_hi ^ 32'h1;
    @(negedge clk_i);
    mem_valid_i = 1'b0;
    if (fault != FAULT_NO_RESP) begin
      exp_src_q.push_back(src_ref(r, pred.two, w0, w1, resp));
      lsu_resp_valid_i = 1'b1;
      lsu_resp_i       = resp;
      @(negedge clk_i);
      lsu_resp_valid_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    while ((exp_mem_q.size() != 0) || (exp_src_q.size() != 0)) @(negedge clk_i);
  endtask

  // exp bits are done, count_mismatch, pending, overflow
  task automatic run_audit(input logic [3:0] exp_flags);
    repeat (2) @(negedge clk_i);
    end_sim_i = 1'b1;
    @(negedge clk_i);
    end_sim_i = 1'b0;
    while (!audit_o.done) @(negedge clk_i);
    check_val("audit_o", 32'(exp_flags), 32'(audit_o));
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    repeat (2) @(negedge clk_i);
    $display("test %s: %0d checks, %0d errors", name, check_cnt - base_checks,
             err_cnt - base_errs);
    base_checks = check_cnt;
    base_errs   = err_cnt;
  endtask

  initial begin
    rst_ni           = 1'b0;
    lsu_req_valid_i  = 1'b0;
    lsu_req_i        = '0;
    mem_valid_i      = 1'b0;
    mem_word_i       = '0;
    lsu_resp_valid_i = 1'b0;
    lsu_resp_i       = '0;
    end_sim_i        = 1'b0;
    rng_state        = 32'd98078;
    check_cnt        = 0;
    err_cnt          = 0;
    base_checks      = 0;
    base_errs        = 0;
    for (int i = 0; i < 256; i++) begin
      mem_model[i[7:0]] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, i[7:0] + 8'h33};
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    repeat (TXN_PER_TEST) run_txn(rand_req(0), FAULT_NONE);
    finish_test("1 aligned words");
    repeat (TXN_PER_TEST) run_txn(rand_req(1), FAULT_NONE);
    finish_test("2 spanning accesses");
    repeat (TXN_PER_TEST) run_txn(rand_req(2), FAULT_NONE);
    finish_test("3 bytes and halves");

    repeat (TXN_PER_TEST) run_txn(rand_req(3), FAULT_NONE);
    req    = rand_req(3);
    req.we = 1'b0;
    run_txn(req, FAULT_RDATA_HI);
    finish_test("4 capabilities");

    repeat (4) begin
      run_txn(rand_req(0), FAULT_BE);
      run_txn(rand_req(0), FAULT_ADDR);
      run_txn(rand_req(0), FAULT_ERR);
    end
    finish_test("5 fault injection");

    repeat (8) run_txn(rand_req(0), FAULT_NONE);
    wait_drain();
    run_audit(4'b1000);
    run_txn(rand_req(0), FAULT_NO_RESP);
    wait_drain();
    run_audit(4'b1110);
    finish_test("6 end audit");

    $display("total: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: testbench/tb_mem_mon_chk.sv
//----------------------------------------
// monitor result assertions
// bound to the memory monitor top level
//----------------------------------------
module tb_mem_mon_chk import mem_mon_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  input chk_result_t mem_chk_o,
  input chk_result_t src_chk_o,
  input audit_t      audit_o
);

  // results stay quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!mem_chk_o.valid && !src_chk_o.valid && !audit_o.done))
    else $error("result output asserted during reset");

  mem_fail_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_chk_o.fail |-> (mem_chk_o.cause != 8'd0))
    else $error("mem_chk_o fail without a cause bit");

  src_fail_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    src_chk_o.fail |-> (src_chk_o.cause != 8'd0))
    else $error("src_chk_o fail without a cause bit");

  // done lasts one cycle
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    audit_o.done |=> !audit_o.done)
    else $error("audit_o.done held longer than one cycle");

endmodule

bind mem_mon_top tb_mem_mon_chk chk_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .mem_chk_o (mem_chk_o),
  .src_chk_o (src_chk_o),
  .audit_o   (audit_o)
);
